// File: src.f
rmt_stream_pkg.sv
rmt_action_pkg.sv
rmt_axis_if.sv
rmt_sync_fifo.sv
rmt_vlan_filter.sv
rmt_parser.sv
rmt_match_stage.sv
rmt_deparser.sv
rmt_pipeline_top.sv
tb_rmt_pipeline.sv

// File: Bender.yml
package:
  name: rmt_pipeline

sources:
  - rmt_stream_pkg.sv
  - rmt_action_pkg.sv
  - rmt_axis_if.sv
  - rmt_sync_fifo.sv
  - rmt_vlan_filter.sv
  - rmt_parser.sv
  - rmt_match_stage.sv
  - rmt_deparser.sv
  - rmt_pipeline_top.sv
  - target: test
    files:
      - tb_rmt_pipeline.sv

// File: tb_rmt_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rmt_pipeline;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_STAGES = 2;
	localparam int STAGE_W = 1;
	// 8 + 16 + 16 + 8 + 24 packets over all tests
	localparam int TOTAL_PKTS = 72;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 200 * TOTAL_PKTS + 500;

	logic                             clk = 1'b0;
	logic                             aresetn;
	logic [31:0]                      vlan_drop_flags;
	logic                             cfg_valid;
	logic [STAGE_W-1:0]               cfg_stage;
	logic [3:0]                       cfg_index;
	rmt_action_pkg::act_op_e          cfg_op;
	rmt_action_pkg::act_field_e       cfg_field;
	logic [15:0]                      cfg_imm;
	logic [63:0]                      s_axis_tdata;
	logic [7:0]                       s_axis_tkeep;
	logic                             s_axis_tlast;
	logic                             s_axis_tvalid;
	logic                             s_axis_tready;
	logic [63:0]                      m_axis_tdata;
	logic [7:0]                       m_axis_tkeep;
	logic                             m_axis_tlast;
	logic                             m_axis_tvalid;
	logic                             m_axis_tready;

	rmt_stream_pkg::beat_t            exp_q [$];
	rmt_stream_pkg::beat_t            exp_beat;
	rmt_stream_pkg::beat_t            held_beat;
	logic                             stall_pending;
	logic                             stall_en;
	logic                             input_stalled;
	logic [31:0]                      stim_seed = 32'h8ad4e3ee;
	logic [31:0]                      ready_seed = 32'h8ad4e3ee ^ 32'h5a5a5a5a;
	string                            test_name;

	// model copy of every action table
	rmt_action_pkg::act_op_e          model_op [NUM_STAGES][16];
	rmt_action_pkg::act_field_e       model_field [NUM_STAGES][16];
	logic [15:0]                      model_imm [NUM_STAGES][16];

	rmt_pipeline_top #(
		.NUM_STAGES(NUM_STAGES), .PKT_FIFO_DEPTH_BITS(4), .PHV_FIFO_DEPTH_BITS(3)
	) i_rmt_pipeline_top (
		.clk(clk), .aresetn(aresetn), .vlan_drop_flags(vlan_drop_flags),
		.cfg_valid(cfg_valid), .cfg_stage(cfg_stage), .cfg_index(cfg_index),
		.cfg_op(cfg_op), .cfg_field(cfg_field), .cfg_imm(cfg_imm),
		.s_axis_tdata(s_axis_tdata), .s_axis_tkeep(s_axis_tkeep), .s_axis_tlast(s_axis_tlast),
		.s_axis_tvalid(s_axis_tvalid), .s_axis_tready(s_axis_tready),
		.m_axis_tdata(m_axis_tdata), .m_axis_tkeep(m_axis_tkeep), .m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] rand32();
		stim_seed = lcg_next(stim_seed);
		return stim_seed;
	endfunction

	task automatic fail_with(input string msg);
		$display("ERROR: %s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string what, input logic [63:0] expv,
			input logic [63:0] actv);
		$display("CHECK FAILED %s %s expected %h actual %h", test_name, what, expv, actv);
		$display("Test failures found");
		$fatal(1);
	endtask

	// stages applied in order with 16-bit wrap
	function automatic logic [63:0] apply_stages(input logic [63:0] hdr);
		logic [15:0] f [3];
		logic [3:0]  idx;
		int          fi;
		f[0] = hdr[63:48];
		f[1] = hdr[47:32];
		f[2] = hdr[31:16];
		idx = hdr[3:0];
		for (int s = 0; s < NUM_STAGES; s++) begin
			fi = int'(model_field[s][idx]);
			case (model_op[s][idx])
				rmt_action_pkg::ACT_SET: f[fi] = model_imm[s][idx];
				rmt_action_pkg::ACT_ADD: f[fi] = f[fi] + model_imm[s][idx];
				rmt_action_pkg::ACT_SUB: f[fi] = f[fi] - model_imm[s][idx];
				default: ;
			endcase
		end
		return {f[0], f[1], f[2], hdr[15:0]};
	endfunction

	task automatic configure(input int stage, input logic [3:0] idx,
			input rmt_action_pkg::act_op_e op, input rmt_action_pkg::act_field_e fld,
			input logic [15:0] imm);
		cfg_stage = STAGE_W'(stage);
		cfg_index = idx;
		cfg_op = op;
		cfg_field = fld;
		cfg_imm = imm;
		cfg_valid = 1'b1;
		@(negedge clk);
		cfg_valid = 1'b0;
		model_op[stage][idx] = op;
		model_field[stage][idx] = fld;
		model_imm[stage][idx] = imm;
	endtask

	// called and returns on a falling edge
	task automatic send_packet(input int len, input logic [63:0] hdr);
		rmt_stream_pkg::beat_t beats [$];
		rmt_stream_pkg::beat_t b;
		logic [31:0]           r;
		for (int i = 0; i < len; i++) begin
			r = rand32();
			b.tdata = (i == 0) ? hdr : {r, rand32()};
			b.tkeep = (i == len - 1) ? r[23:16] : 8'hff;
			b.tlast = (i == len - 1);
			beats.push_back(b);
		end
		if (!vlan_drop_flags[hdr[4:0]]) begin
			foreach (beats[i]) begin
				b = beats[i];
				if (i == 0)
					b.tdata = apply_stages(b.tdata);
				exp_q.push_back(b);
			end
		end
		foreach (beats[i]) begin
			s_axis_tdata = beats[i].tdata;
			s_axis_tkeep = beats[i].tkeep;
			s_axis_tlast = beats[i].tlast;
			s_axis_tvalid = 1'b1;
			while (!s_axis_tready) begin
				input_stalled = 1'b1;
				@(negedge clk);
			end
			@(negedge clk);
		end
		s_axis_tvalid = 1'b0;
	endtask

	task automatic send_random(input logic [11:0] vlan);
		logic [31:0] r1;
		logic [31:0] r2;
		r1 = rand32();
		r2 = rand32();
		send_packet(1 + int'(r1[31:16] % 6), {r1[15:0], r2[31:16], r2[15:0] ^ r1[31:16],
			r1[27:24], vlan});
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (8) @(negedge clk);
	endtask

	// ready is chosen and the handshake judged on the falling edge
	always @(negedge clk) begin
		if (aresetn) begin
			if (stall_pending) begin
				assert (m_axis_tvalid)
					else fail_with("m_axis_tvalid fell while the beat was stalled");
				assert (m_axis_tdata == held_beat.tdata)
					else report_mismatch("held tdata", held_beat.tdata, m_axis_tdata);
				assert ({m_axis_tkeep, m_axis_tlast} == {held_beat.tkeep, held_beat.tlast})
					else report_mismatch("held tkeep/tlast",
						64'({held_beat.tkeep, held_beat.tlast}),
						64'({m_axis_tkeep, m_axis_tlast}));
			end
			ready_seed = lcg_next(ready_seed);
			m_axis_tready = stall_en ? (ready_seed[21] & ready_seed[20]) : 1'b1;
			if (m_axis_tvalid && m_axis_tready) begin
				assert (exp_q.size() != 0) else fail_with("output beat with no packet expected");
				exp_beat = exp_q.pop_front();
				assert (m_axis_tdata == exp_beat.tdata)
					else report_mismatch("tdata", exp_beat.tdata, m_axis_tdata);
				assert (m_axis_tkeep == exp_beat.tkeep)
					else report_mismatch("tkeep", 64'(exp_beat.tkeep), 64'(m_axis_tkeep));
				assert (m_axis_tlast == exp_beat.tlast)
					else report_mismatch("tlast", 64'(exp_beat.tlast), 64'(m_axis_tlast));
			end
			stall_pending = m_axis_tvalid && !m_axis_tready;
			held_beat.tdata = m_axis_tdata;
			held_beat.tkeep = m_axis_tkeep;
			held_beat.tlast = m_axis_tlast;
		end
	end

	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("ERROR: timeout, the pipeline stopped delivering packets");
		$display("Test failures found");
		$fatal(1);
	end

	initial begin
		logic [31:0] r;
		aresetn = 1'b0;
		vlan_drop_flags = 32'h0;
		cfg_valid = 1'b0;
		cfg_stage = '0;
		cfg_index = '0;
		cfg_op = rmt_action_pkg::ACT_NOP;
		cfg_field = rmt_action_pkg::FLD_A;
		cfg_imm = '0;
		s_axis_tdata = '0;
		s_axis_tkeep = '0;
		s_axis_tlast = 1'b0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b1;
		stall_en = 1'b0;
		stall_pending = 1'b0;
		input_stalled = 1'b0;
		for (int s = 0; s < NUM_STAGES; s++) begin
			for (int i = 0; i < 16; i++) begin
				model_op[s][i] = rmt_action_pkg::ACT_NOP;
				model_field[s][i] = rmt_action_pkg::FLD_A;
				model_imm[s][i] = '0;
			end
		end
		repeat (RESET_CYCLES) @(negedge clk);
		aresetn = 1'b1;
		@(negedge clk);

		test_name = "passthrough";
		for (int i = 0; i < 8; i++) begin
			r = rand32();
			send_random(r[31:20]);
		end
		drain();

		// even vlan ids hit a set flag
		test_name = "vlan_drop";
		vlan_drop_flags = 32'h5555_5555;
		for (int i = 0; i < 16; i++) begin
			r = rand32();
			send_random({r[31:21], i[0]});
		end
		drain();
		vlan_drop_flags = 32'h0;

		test_name = "actions";
		configure(0, 4'd1, rmt_action_pkg::ACT_ADD, rmt_action_pkg::FLD_A, 16'hf000);
		configure(0, 4'd2, rmt_action_pkg::ACT_SUB, rmt_action_pkg::FLD_B, 16'hc000);
		configure(0, 4'd3, rmt_action_pkg::ACT_SET, rmt_action_pkg::FLD_C, 16'hbeef);
		configure(1, 4'd4, rmt_action_pkg::ACT_ADD, rmt_action_pkg::FLD_C, 16'hffff);
		configure(1, 4'd5, rmt_action_pkg::ACT_SUB, rmt_action_pkg::FLD_A, 16'h8001);
		configure(1, 4'd6, rmt_action_pkg::ACT_SET, rmt_action_pkg::FLD_B, 16'h1234);
		for (int i = 0; i < 16; i++) begin
			r = rand32();
			send_random({r[31:24], 1'b0, i[2:0]});
		end
		drain();

		// both stages on one field
		test_name = "compose";
		configure(0, 4'd8, rmt_action_pkg::ACT_ADD, rmt_action_pkg::FLD_B, 16'h0100);
		configure(1, 4'd8, rmt_action_pkg::ACT_SUB, rmt_action_pkg::FLD_B, 16'h0003);
		configure(0, 4'd9, rmt_action_pkg::ACT_SET, rmt_action_pkg::FLD_A, 16'h1111);
		configure(1, 4'd9, rmt_action_pkg::ACT_ADD, rmt_action_pkg::FLD_A, 16'hf222);
		for (int i = 0; i < 8; i++) begin
			r = rand32();
			send_random({r[31:24], 3'b100, i[0]});
		end
		drain();

		test_name = "backpressure";
		stall_en = 1'b1;
		input_stalled = 1'b0;
		vlan_drop_flags = 32'h0f0f_0000;
		for (int i = 0; i < 24; i++) begin
			r = rand32();
			send_random(r[31:20]);
		end
		drain();
		stall_en = 1'b0;
		assert (input_stalled)
			else fail_with("s_axis_tready never fell while the output was stalled");

		if (exp_q.size() != 0) begin
			$display("ERROR: %0d expected beats never came out", exp_q.size());
			$display("Test failures found");
			$fatal(1);
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: rmt_pipeline_top.sv
`timescale 1ns/1ps
`default_nettype none

module rmt_pipeline_top #(
	parameter int NUM_STAGES = 2,
	parameter int PKT_FIFO_DEPTH_BITS = 4,
	parameter int PHV_FIFO_DEPTH_BITS = 3,
	localparam int STAGE_W = (NUM_STAGES > 1) ? $clog2(NUM_STAGES) : 1
) (
	input  wire                                clk,
	input  wire                                aresetn,
	input  wire  [31:0]                        vlan_drop_flags,
	input  wire                                cfg_valid,
	input  wire  [STAGE_W-1:0]                 cfg_stage,
	input  wire  [rmt_action_pkg::IDX_W-1:0]   cfg_index,
	input  wire  rmt_action_pkg::act_op_e      cfg_op,
	input  wire  rmt_action_pkg::act_field_e   cfg_field,
	input  wire  [rmt_stream_pkg::FIELD_W-1:0] cfg_imm,
	input  wire  [rmt_stream_pkg::DATA_W-1:0]  s_axis_tdata,
	input  wire  [rmt_stream_pkg::KEEP_W-1:0]  s_axis_tkeep,
	input  wire                                s_axis_tlast,
	input  wire                                s_axis_tvalid,
	output logic                               s_axis_tready,
	output logic [rmt_stream_pkg::DATA_W-1:0]  m_axis_tdata,
	output logic [rmt_stream_pkg::KEEP_W-1:0]  m_axis_tkeep,
	output logic                               m_axis_tlast,
	output logic                               m_axis_tvalid,
	input  wire                                m_axis_tready
);

	rmt_axis_if filt_axis ();

	rmt_stream_pkg::beat_t pkt_in_beat;
	rmt_stream_pkg::beat_t pkt_out_beat;
	rmt_stream_pkg::phv_t  stg_phv [NUM_STAGES+1];
	rmt_stream_pkg::phv_t  phv_head;
	logic [NUM_STAGES:0]   stg_valid;
	logic pkt_wr;
	logic pkt_rd;
	logic pkt_empty;
	logic pkt_nearly_full;
	logic phv_rd;
	logic phv_empty;
	logic phv_nearly_full;

	rmt_vlan_filter i_rmt_vlan_filter (
		.clk(clk), .aresetn(aresetn), .vlan_drop_flags(vlan_drop_flags),
		.s_axis_tdata(s_axis_tdata), .s_axis_tkeep(s_axis_tkeep),
		.s_axis_tlast(s_axis_tlast), .s_axis_tvalid(s_axis_tvalid),
		.s_axis_tready(s_axis_tready), .m(filt_axis.src)
	);

	rmt_parser i_rmt_parser (
		.clk(clk), .aresetn(aresetn), .s(filt_axis.snk),
		.pkt_wr(pkt_wr), .pkt_beat(pkt_in_beat),
		.pkt_nearly_full(pkt_nearly_full), .phv_nearly_full(phv_nearly_full),
		.phv(stg_phv[0]), .phv_valid(stg_valid[0])
	);

	// one stage per table, chained in order
	for (genvar s = 0; s < NUM_STAGES; s++) begin : g_stage
		rmt_match_stage #(.STAGE_IDX(s), .STAGE_W(STAGE_W)) i_rmt_match_stage (
			.clk(clk), .aresetn(aresetn), .cfg_valid(cfg_valid), .cfg_stage(cfg_stage),
			.cfg_index(cfg_index), .cfg_op(cfg_op), .cfg_field(cfg_field), .cfg_imm(cfg_imm),
			.phv_in(stg_phv[s]), .phv_in_valid(stg_valid[s]),
			.phv_out(stg_phv[s+1]), .phv_out_valid(stg_valid[s+1])
		);
	end

	rmt_sync_fifo #(
		.WIDTH($bits(rmt_stream_pkg::beat_t)), .DEPTH_BITS(PKT_FIFO_DEPTH_BITS), .MARGIN(1)
	) i_pkt_fifo (
		.clk(clk), .aresetn(aresetn), .wr_en(pkt_wr), .din(pkt_in_beat),
		.rd_en(pkt_rd), .dout(pkt_out_beat), .empty(pkt_empty), .nearly_full(pkt_nearly_full)
	);

	// room for every header still inside the stages
	rmt_sync_fifo #(
		.WIDTH($bits(rmt_stream_pkg::phv_t)), .DEPTH_BITS(PHV_FIFO_DEPTH_BITS),
		.MARGIN(NUM_STAGES + 1)
	) i_phv_fifo (
		.clk(clk), .aresetn(aresetn), .wr_en(stg_valid[NUM_STAGES]), .din(stg_phv[NUM_STAGES]),
		.rd_en(phv_rd), .dout(phv_head), .empty(phv_empty), .nearly_full(phv_nearly_full)
	);

	rmt_deparser i_rmt_deparser (
		.clk(clk), .aresetn(aresetn),
		.pkt_beat(pkt_out_beat), .pkt_empty(pkt_empty), .pkt_rd(pkt_rd),
		.phv(phv_head), .phv_empty(phv_empty), .phv_rd(phv_rd),
		.m_axis_tdata(m_axis_tdata), .m_axis_tkeep(m_axis_tkeep), .m_axis_tlast(m_axis_tlast),
		.m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready)
	);

endmodule

`default_nettype wire

// File: rmt_deparser.sv
`timescale 1ns/1ps
`default_nettype none

module rmt_deparser (
	input  wire                               clk,
	input  wire                               aresetn,
	input  wire  rmt_stream_pkg::beat_t       pkt_beat,
	input  wire                               pkt_empty,
	output logic                              pkt_rd,
	input  wire  rmt_stream_pkg::phv_t        phv,
	input  wire                               phv_empty,
	output logic                              phv_rd,
	output logic [rmt_stream_pkg::DATA_W-1:0] m_axis_tdata,
	output logic [rmt_stream_pkg::KEEP_W-1:0] m_axis_tkeep,
	output logic                              m_axis_tlast,
	output logic                              m_axis_tvalid,
	input  wire                               m_axis_tready
);

	logic                              first;
	logic                              out_free;
	logic                              can_go;
	logic [rmt_stream_pkg::DATA_W-1:0] hdr_data;

	assign out_free = ~m_axis_tvalid | m_axis_tready;
	// header vector stays at the FIFO head for the whole packet
	assign can_go = ~pkt_empty & ~phv_empty & out_free;
	assign pkt_rd = can_go;
	assign phv_rd = can_go & pkt_beat.tlast;

	// patch fields, tag stays as received
	always_comb begin
		hdr_data = pkt_beat.tdata;
		hdr_data[rmt_stream_pkg::FIELD_A_LSB +: rmt_stream_pkg::FIELD_W] = phv.a;
		hdr_data[rmt_stream_pkg::FIELD_B_LSB +: rmt_stream_pkg::FIELD_W] = phv.b;
		hdr_data[rmt_stream_pkg::FIELD_C_LSB +: rmt_stream_pkg::FIELD_W] = phv.c;
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			first <= 1'b1;
			m_axis_tvalid <= 1'b0;
		end else begin
			if (out_free)
				m_axis_tvalid <= can_go;
			if (can_go)
				first <= pkt_beat.tlast;
		end
	end

	always_ff @(posedge clk) begin
		if (can_go) begin
			m_axis_tdata <= first ? hdr_data : pkt_beat.tdata;
			m_axis_tkeep <= pkt_beat.tkeep;
			m_axis_tlast <= pkt_beat.tlast;
		end
	end

endmodule

`default_nettype wire

// File: rmt_match_stage.sv
`timescale 1ns/1ps
`default_nettype none

module rmt_match_stage #(
	parameter int STAGE_IDX = 0,
	parameter int STAGE_W = 1
) (
	input  wire                                     clk,
	input  wire                                     aresetn,
	input  wire                                     cfg_valid,
	input  wire  [STAGE_W-1:0]                      cfg_stage,
	input  wire  [rmt_action_pkg::IDX_W-1:0]        cfg_index,
	input  wire  rmt_action_pkg::act_op_e           cfg_op,
	input  wire  rmt_action_pkg::act_field_e        cfg_field,
	input  wire  [rmt_stream_pkg::FIELD_W-1:0]      cfg_imm,
	input  wire  rmt_stream_pkg::phv_t              phv_in,
	input  wire                                     phv_in_valid,
	output rmt_stream_pkg::phv_t                    phv_out,
	output logic                                    phv_out_valid
);

	rmt_action_pkg::action_t          table_q [rmt_action_pkg::TABLE_DEPTH];
	rmt_action_pkg::action_t          entry;
	rmt_stream_pkg::phv_t             phv_next;
	logic [rmt_stream_pkg::FIELD_W-1:0] operand;
	logic [rmt_stream_pkg::FIELD_W-1:0] result;

	// table write, only for this stage
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			for (int i = 0; i < rmt_action_pkg::TABLE_DEPTH; i++)
				table_q[i] <= '{op: rmt_action_pkg::ACT_NOP, field: rmt_action_pkg::FLD_A, imm: '0};
		end else if (cfg_valid && (cfg_stage == STAGE_W'(STAGE_IDX))) begin
			table_q[cfg_index] <= '{op: cfg_op, field: cfg_field, imm: cfg_imm};
		end
	end

	// low vlan bits index the table
	always_comb begin
		entry = table_q[phv_in.vlan[rmt_action_pkg::IDX_W-1:0]];
		phv_next = phv_in;
		case (entry.field)
			rmt_action_pkg::FLD_A: operand = phv_in.a;
			rmt_action_pkg::FLD_B: operand = phv_in.b;
			default:               operand = phv_in.c;
		endcase
		// add and sub wrap at 16 bits
		case (entry.op)
			rmt_action_pkg::ACT_SET: result = entry.imm;
			rmt_action_pkg::ACT_ADD: result = operand + entry.imm;
			rmt_action_pkg::ACT_SUB: result = operand - entry.imm;
			default:                 result = operand;
		endcase
		case (entry.field)
			rmt_action_pkg::FLD_A: phv_next.a = result;
			rmt_action_pkg::FLD_B: phv_next.b = result;
			rmt_action_pkg::FLD_C: phv_next.c = result;
			default:               phv_next = phv_in;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			phv_out_valid <= 1'b0;
		else
			phv_out_valid <= phv_in_valid;
	end

	always_ff @(posedge clk) begin
		if (phv_in_valid)
			phv_out <= phv_next;
	end

endmodule

`default_nettype wire

// File: rmt_parser.sv
`timescale 1ns/1ps
`default_nettype none

module rmt_parser (
	input  wire                          clk,
	input  wire                          aresetn,
	rmt_axis_if.snk                      s,
	output logic                         pkt_wr,
	output rmt_stream_pkg::beat_t        pkt_beat,
	input  wire                          pkt_nearly_full,
	input  wire                          phv_nearly_full,
	output rmt_stream_pkg::phv_t         phv,
	output logic                         phv_valid
);

	logic first;
	logic accept;

	// a new header also needs room in the header FIFO
	assign s.tready = ~pkt_nearly_full & (~first | ~phv_nearly_full);
	assign accept = s.tvalid & s.tready;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			first <= 1'b1;
			pkt_wr <= 1'b0;
			phv_valid <= 1'b0;
		end else begin
			pkt_wr <= accept;
			phv_valid <= accept & first;
			if (accept)
				first <= s.tlast;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pkt_beat.tdata <= s.tdata;
			pkt_beat.tkeep <= s.tkeep;
			pkt_beat.tlast <= s.tlast;
		end
		// fields come from the first beat only
		if (accept & first) begin
			phv.a <= s.tdata[rmt_stream_pkg::FIELD_A_LSB +: rmt_stream_pkg::FIELD_W];
			phv.b <= s.tdata[rmt_stream_pkg::FIELD_B_LSB +: rmt_stream_pkg::FIELD_W];
			phv.c <= s.tdata[rmt_stream_pkg::FIELD_C_LSB +: rmt_stream_pkg::FIELD_W];
			phv.tag <= s.tdata[rmt_stream_pkg::TAG_LSB +: rmt_stream_pkg::FIELD_W];
			phv.vlan <= s.tdata[rmt_stream_pkg::TAG_LSB +: rmt_stream_pkg::VLAN_W];
		end
	end

endmodule

`default_nettype wire

// File: rmt_vlan_filter.sv
`timescale 1ns/1ps
`default_nettype none

module rmt_vlan_filter (
	input  wire                               clk,
	input  wire                               aresetn,
	input  wire  [31:0]                       vlan_drop_flags,
	input  wire  [rmt_stream_pkg::DATA_W-1:0] s_axis_tdata,
	input  wire  [rmt_stream_pkg::KEEP_W-1:0] s_axis_tkeep,
	input  wire                               s_axis_tlast,
	input  wire                               s_axis_tvalid,
	output logic                              s_axis_tready,
	rmt_axis_if.src                           m
);

	logic       in_first;
	logic       drop_hold;
	logic       drop_cur;
	logic       out_free;
	logic       accept;
	logic [4:0] drop_sel;

	// vlan id modulo 32 picks the flag
	assign drop_sel = s_axis_tdata[rmt_stream_pkg::TAG_LSB +: 5];
	assign drop_cur = in_first ? vlan_drop_flags[drop_sel] : drop_hold;

	// output register empty or draining
	assign out_free = ~m.tvalid | m.tready;
	assign s_axis_tready = out_free;
	assign accept = s_axis_tvalid & out_free;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			in_first <= 1'b1;
			drop_hold <= 1'b0;
			m.tvalid <= 1'b0;
		end else begin
			if (accept) begin
				in_first <= s_axis_tlast;
				// decision sticks until tlast
				drop_hold <= drop_cur;
			end
			if (out_free)
				m.tvalid <= accept & ~drop_cur;
		end
	end

	// dropped beats are swallowed here
	always_ff @(posedge clk) begin
		if (accept & ~drop_cur) begin
			m.tdata <= s_axis_tdata;
			m.tkeep <= s_axis_tkeep;
			m.tlast <= s_axis_tlast;
		end
	end

endmodule

`default_nettype wire

// File: rmt_sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rmt_sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH_BITS = 4,
	parameter int MARGIN = 1
) (
	input  wire              clk,
	input  wire              aresetn,
	input  wire              wr_en,
	input  wire  [WIDTH-1:0] din,
	input  wire              rd_en,
	output logic [WIDTH-1:0] dout,
	output logic             empty,
	output logic             nearly_full
);

	localparam int DEPTH = 1 << DEPTH_BITS;
	localparam logic [DEPTH_BITS:0] LIMIT = (DEPTH_BITS + 1)'(DEPTH - MARGIN);

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS:0]   count;
	logic [DEPTH_BITS:0]   used;
	logic                  do_rd;

	// head entry shows without a read
	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign do_rd = rd_en & ~empty;

	// a write landing this cycle already counts as used
	assign used = count + {{DEPTH_BITS{1'b0}}, wr_en};
	assign nearly_full = (used > LIMIT);

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + {{DEPTH_BITS{1'b0}}, wr_en} - {{DEPTH_BITS{1'b0}}, do_rd};
		end
	end

endmodule

`default_nettype wire

// File: rmt_axis_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rmt_axis_if;

	logic [rmt_stream_pkg::DATA_W-1:0] tdata;
	logic [rmt_stream_pkg::KEEP_W-1:0] tkeep;
	logic                              tlast;
	logic                              tvalid;
	logic                              tready;

	// beat moves on tvalid and tready both high
	modport src (output tdata, output tkeep, output tlast, output tvalid, input tready);
	modport snk (input tdata, input tkeep, input tlast, input tvalid, output tready);

endinterface

`default_nettype wire

// File: rmt_action_pkg.sv
`default_nettype none

package rmt_action_pkg;

	// per-stage action table size
	localparam int TABLE_DEPTH = 16;
	localparam int IDX_W = $clog2(TABLE_DEPTH);

	typedef enum logic [1:0] {
		ACT_NOP,
		ACT_SET,
		ACT_ADD,
		ACT_SUB
	} act_op_e;

	typedef enum logic [1:0] {
		FLD_A,
		FLD_B,
		FLD_C
	} act_field_e;

	typedef struct packed {
		act_op_e                             op;
		act_field_e                          field;
		logic [rmt_stream_pkg::FIELD_W-1:0] imm;
	} action_t;

endpackage

`default_nettype wire

// File: rmt_stream_pkg.sv
`default_nettype none

package rmt_stream_pkg;

	// beat stream widths
	localparam int DATA_W = 64;
	localparam int KEEP_W = DATA_W / 8;

	// header layout in the first beat
	localparam int FIELD_W = 16;
	localparam int VLAN_W = 12;
	localparam int FIELD_A_LSB = 48;
	localparam int FIELD_B_LSB = 32;
	localparam int FIELD_C_LSB = 16;
	localparam int TAG_LSB = 0;

	typedef struct packed {
		logic [DATA_W-1:0] tdata;
		logic [KEEP_W-1:0] tkeep;
		logic              tlast;
	} beat_t;

	// header vector, vlan id is the low part of the tag
	typedef struct packed {
		logic [FIELD_W-1:0] a;
		logic [FIELD_W-1:0] b;
		logic [FIELD_W-1:0] c;
		logic [FIELD_W-1:0] tag;
		logic [VLAN_W-1:0]  vlan;
	} phv_t;

endpackage

`default_nettype wire
